/* hw/shift_pkg.sv */
`default_nettype none

package shift_pkg;

  // register mode as driven on the mode input.
  typedef enum logic [1:0] {
    // serial in at the top, shift toward bit 0.
    mode_siso_right = 2'b00,
    // serial in at bit 0, shift toward the top.
    mode_siso_left  = 2'b01,
    // parallel load, then drain toward bit 0 with zero fill.
    mode_piso       = 2'b10,
    // parallel load, then hold.
    mode_pipo       = 2'b11
  } mode_e;

  // default register width. the low nibble is the ecc field.
  localparam int default_width = 64;

endpackage

`default_nettype wire

/* hw/ecc_pkg.sv */
`default_nettype none

package ecc_pkg;

  // bit 0 covers p1, bit 1 covers p2, bit 2 covers p3.
  typedef logic [2:0] syndrome_t;

  // check bits in the order p1, p2, p3 from bit 0 up.
  typedef logic [2:0] check_t;

  typedef enum logic [1:0] {
    err_none  = 2'd0,
    err_data  = 2'd1,
    err_check = 2'd2
  } err_kind_e;

  // the seven protected positions of the hamming(7,4) word.
  typedef enum logic [2:0] {
    inj_d0 = 3'd0,
    inj_d1 = 3'd1,
    inj_d2 = 3'd2,
    inj_d3 = 3'd3,
    inj_p1 = 3'd4,
    inj_p2 = 3'd5,
    inj_p3 = 3'd6
  } inject_pos_e;

  // check bits for a four-bit data field.
  function automatic check_t encode_check(input logic [3:0] d);
    check_t c;
    c[0] = d[0] ^ d[2] ^ d[3];
    c[1] = d[0] ^ d[1] ^ d[3];
    c[2] = d[0] ^ d[1] ^ d[2];
    return c;
  endfunction

  // syndrome seen when only the given position is flipped.
  function automatic syndrome_t pos_syndrome(input inject_pos_e pos);
    syndrome_t s;
    case (pos)
      inj_d0:  s = 3'b111;
      inj_d1:  s = 3'b110;
      inj_d2:  s = 3'b101;
      inj_d3:  s = 3'b011;
      inj_p1:  s = 3'b001;
      inj_p2:  s = 3'b010;
      inj_p3:  s = 3'b100;
      default: s = 3'b000;
    endcase
    return s;
  endfunction

endpackage

`default_nettype wire

/* hw/syndrome_calc.sv */
`timescale 1ns/1ps
`default_nettype none

module syndrome_calc
  import ecc_pkg::*;
(
  input  logic [3:0] data,
  input  check_t     check,
  output syndrome_t  syndrome
);

  check_t expect_check;

  // each bit is a stored check bit against the parity recomputed
  // over its three covered data bits.
  always_comb begin
    expect_check = encode_check(data);
    syndrome     = check ^ expect_check;
  end

endmodule

`default_nettype wire

/* hw/error_corrector.sv */
`timescale 1ns/1ps
`default_nettype none

module error_corrector
  import ecc_pkg::*;
#(
  parameter int WIDTH = 64
) (
  input  syndrome_t        syndrome,
  input  logic [WIDTH-1:0] data,
  input  check_t           check,
  output logic             fault,
  output logic [WIDTH-1:0] fixed_data,
  output check_t           fixed_check,
  output err_kind_e        err_kind
);

  assign fault = |syndrome;

  // flip whichever position produces the observed syndrome.
  // a zero syndrome matches no position, so the word passes through.
  always_comb begin
    fixed_data  = data;
    fixed_check = check;
    for (int i = 0; i < 4; i++) begin
      if (syndrome == pos_syndrome(inject_pos_e'(i))) begin
        fixed_data[i] = ~data[i];
      end
    end
    for (int j = 0; j < 3; j++) begin
      if (syndrome == pos_syndrome(inject_pos_e'(j + 4))) begin
        fixed_check[j] = ~check[j];
      end
    end
  end

  // weight one points at a check bit, heavier ones at a data bit.
  always_comb begin
    if (syndrome == '0) begin
      err_kind = err_none;
    end else if ($onehot(syndrome)) begin
      err_kind = err_check;
    end else begin
      err_kind = err_data;
    end
  end

endmodule

`default_nettype wire

/* hw/shift_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module shift_datapath
  import shift_pkg::*, ecc_pkg::*;
#(
  parameter int WIDTH = 64
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             enable,
  input  mode_e            mode,
  input  logic             load,
  input  logic             serial_in,
  input  logic [WIDTH-1:0] parallel_in,
  input  logic             inject,
  input  inject_pos_e      inject_pos,
  input  logic             fault,
  input  logic [WIDTH-1:0] fixed_data,
  input  check_t           fixed_check,
  output logic [WIDTH-1:0] stored_data,
  output check_t           stored_check,
  output logic             serial_out
);

  logic [WIDTH-1:0] next_data;
  check_t           next_check;
  logic [WIDTH-1:0] data_flip;
  check_t           check_flip;

  // the next word is built from the corrected word, so a pending
  // single-bit error never shifts out.
  always_comb begin
    case (mode)
      mode_siso_right: next_data = {serial_in, fixed_data[WIDTH-1:1]};
      mode_siso_left:  next_data = {fixed_data[WIDTH-2:0], serial_in};
      mode_piso:       next_data = load ? parallel_in : {1'b0, fixed_data[WIDTH-1:1]};
      mode_pipo:       next_data = load ? parallel_in : fixed_data;
      default:         next_data = fixed_data;
    endcase
    next_check = encode_check(next_data[3:0]);
  end

  // one-hot flip mask for the injected position.
  always_comb begin
    data_flip  = '0;
    check_flip = '0;
    case (inject_pos)
      inj_d0:  data_flip[0]  = 1'b1;
      inj_d1:  data_flip[1]  = 1'b1;
      inj_d2:  data_flip[2]  = 1'b1;
      inj_d3:  data_flip[3]  = 1'b1;
      inj_p1:  check_flip[0] = 1'b1;
      inj_p2:  check_flip[1] = 1'b1;
      inj_p3:  check_flip[2] = 1'b1;
      default: ;
    endcase
  end

  // shift beats inject, inject beats scrub.
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      stored_data  <= '0;
      stored_check <= '0;
    end else if (enable) begin
      stored_data  <= next_data;
      stored_check <= next_check;
    end else if (inject) begin
      stored_data  <= stored_data ^ data_flip;
      stored_check <= stored_check ^ check_flip;
    end else if (fault) begin
      // scrub write-back of the repaired word.
      stored_data  <= fixed_data;
      stored_check <= fixed_check;
    end
  end

  // right-moving modes tap bit 0, the others tap the top bit.
  always_comb begin
    if (mode == mode_siso_right || mode == mode_piso) begin
      serial_out = stored_data[0];
    end else begin
      serial_out = stored_data[WIDTH-1];
    end
  end

endmodule

`default_nettype wire

/* hw/ecc_shift_register.sv */
`timescale 1ns/1ps
`default_nettype none

module ecc_shift_register
  import shift_pkg::*, ecc_pkg::*;
#(
  parameter int WIDTH = default_width
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             enable,
  input  mode_e            mode,
  input  logic             load,
  input  logic             serial_in,
  input  logic [WIDTH-1:0] parallel_in,
  input  logic             inject,
  input  inject_pos_e      inject_pos,
  output logic             serial_out,
  output logic [WIDTH-1:0] parallel_out,
  output err_kind_e        err_kind
);

  logic [WIDTH-1:0] stored_data;
  check_t           stored_check;
  syndrome_t        syndrome;
  logic             fault;
  logic [WIDTH-1:0] fixed_data;
  check_t           fixed_check;

  shift_datapath #(
    .WIDTH(WIDTH)
  ) datapath_inst (
    .clk         (clk),
    .rst         (rst),
    .enable      (enable),
    .mode        (mode),
    .load        (load),
    .serial_in   (serial_in),
    .parallel_in (parallel_in),
    .inject      (inject),
    .inject_pos  (inject_pos),
    .fault       (fault),
    .fixed_data  (fixed_data),
    .fixed_check (fixed_check),
    .stored_data (stored_data),
    .stored_check(stored_check),
    .serial_out  (serial_out)
  );

  // only the low nibble is protected.
  syndrome_calc syndrome_inst (
    .data    (stored_data[3:0]),
    .check   (stored_check),
    .syndrome(syndrome)
  );

  error_corrector #(
    .WIDTH(WIDTH)
  ) corrector_inst (
    .syndrome   (syndrome),
    .data       (stored_data),
    .check      (stored_check),
    .fault      (fault),
    .fixed_data (fixed_data),
    .fixed_check(fixed_check),
    .err_kind   (err_kind)
  );

  // parallel view is always the corrected word.
  assign parallel_out = fixed_data;

endmodule

`default_nettype wire

/* tests/tb_ecc_shift_register.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ecc_shift_register
  import shift_pkg::*, ecc_pkg::*;
();

  localparam int W = default_width;
  localparam int period_ns = 4;
  localparam int reset_cycles = 16;

  typedef struct packed {
    mode_e        mode;
    logic         load;
    logic         enable;
    logic         use_lfsr;
    logic [W-1:0] value;
    logic         inject;
    inject_pos_e  pos;
    int           cycles;
    err_kind_e    kind;
  } row_t;

  logic         clk;
  logic         rst;
  logic         enable;
  mode_e        mode;
  logic         load;
  logic         serial_in;
  logic [W-1:0] parallel_in;
  logic         inject;
  inject_pos_e  inject_pos;
  logic         serial_out;
  logic [W-1:0] parallel_out;
  err_kind_e    err_kind;

  row_t         rows[$];
  logic [31:0]  lfsr_state;
  logic [W-1:0] model_word;
  logic         model_pend;
  inject_pos_e  model_pos;
  int           errors;
  int           row_base;
  int           prev_row;
  logic         prev_last;

  ecc_shift_register #(
    .WIDTH(W)
  ) uut (
    .clk         (clk),
    .rst         (rst),
    .enable      (enable),
    .mode        (mode),
    .load        (load),
    .serial_in   (serial_in),
    .parallel_in (parallel_in),
    .inject      (inject),
    .inject_pos  (inject_pos),
    .serial_out  (serial_out),
    .parallel_out(parallel_out),
    .err_kind    (err_kind)
  );

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  task automatic take_bit(output logic b);
    b = lfsr_state[0];
    lfsr_state = lfsr_step(lfsr_state);
  endtask

  task automatic take_word(output logic [W-1:0] w);
    logic b;
    for (int i = 0; i < W; i++) begin
      take_bit(b);
      w[i] = b;
    end
  endtask

  // hamming(7,4) syndromes as p3 p2 p1; weight one means a check bit.
  function automatic err_kind_e expected_kind(input inject_pos_e pos);
    logic [2:0] syn;
    err_kind_e  kind;
    case (pos)
      inj_d0:  syn = 3'b111;
      inj_d1:  syn = 3'b110;
      inj_d2:  syn = 3'b101;
      inj_d3:  syn = 3'b011;
      inj_p1:  syn = 3'b001;
      inj_p2:  syn = 3'b010;
      inj_p3:  syn = 3'b100;
      default: syn = 3'b000;
    endcase
    if (syn == 3'b000) begin
      kind = err_none;
    end else if ($countones(syn) == 1) begin
      kind = err_check;
    end else begin
      kind = err_data;
    end
    return kind;
  endfunction

  function automatic logic [W-1:0] next_word(input mode_e md, input logic ld,
      input logic sin, input logic [W-1:0] pin, input logic [W-1:0] w);
    logic [W-1:0] n;
    case (md)
      mode_siso_right: n = {sin, w[W-1:1]};
      mode_siso_left:  n = {w[W-2:0], sin};
      mode_piso:       n = ld ? pin : {1'b0, w[W-1:1]};
      default:         n = ld ? pin : w;
    endcase
    return n;
  endfunction

  task automatic check_word(input logic [W-1:0] exp, input logic [W-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("Fail parallel_out expected %h got %h at %0t", exp, act, $time);
    end
  endtask

  task automatic check_bit(input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("Fail serial_out expected %h got %h at %0t", exp, act, $time);
    end
  endtask

  task automatic check_kind(input err_kind_e exp, input err_kind_e act);
    if (act !== exp) begin
      errors++;
      $display("Fail err_kind expected %h got %h at %0t", exp, act, $time);
    end
  endtask

  // the serial tap sees the stored word, so a flipped d0 shows up there.
  task automatic check_outputs();
    logic      tap;
    err_kind_e kind;
    if (mode == mode_siso_right || mode == mode_piso) begin
      tap = model_word[0] ^ (model_pend && model_pos == inj_d0);
    end else begin
      tap = model_word[W-1];
    end
    kind = model_pend ? expected_kind(model_pos) : err_none;
    check_word(model_word, parallel_out);
    check_bit(tap, serial_out);
    check_kind(kind, err_kind);
  endtask

  task automatic close_row();
    mode_e md;
    if (prev_last) begin
      md = rows[prev_row].mode;
      check_kind(rows[prev_row].kind, err_kind);
      if (errors == row_base) begin
        $display("test %0d %s over %0d cycles passed", prev_row, md.name(),
                 rows[prev_row].cycles);
      end else begin
        $display("test %0d %s over %0d cycles failed with %0d errors", prev_row,
                 md.name(), rows[prev_row].cycles, errors - row_base);
      end
      row_base = errors;
      prev_last = 1'b0;
    end
  endtask

  // called at a rising edge; checks what the previous edge stored.
  task automatic step(input int r, input int c);
    row_t         rw;
    logic         sin;
    logic [W-1:0] pin;
    rw = rows[r];
    sin = 1'b0;
    pin = '0;
    if (rw.load && rw.use_lfsr) begin
      take_word(pin);
    end else if (rw.load) begin
      pin = rw.value;
    end else if (rw.use_lfsr) begin
      take_bit(sin);
    end else begin
      sin = rw.value[c % W];
    end
    enable <= rw.enable;
    mode <= rw.mode;
    load <= rw.load;
    serial_in <= sin;
    parallel_in <= pin;
    inject <= rw.inject && c == 0;
    inject_pos <= rw.pos;
    @(negedge clk);
    check_outputs();
    close_row();
    if (rw.enable) begin
      model_word = next_word(rw.mode, rw.load, sin, pin, model_word);
      model_pend = 1'b0;
    end else if (rw.inject && c == 0) begin
      model_pend = 1'b1;
      model_pos = rw.pos;
    end else begin
      // idle edge scrubs any pending error.
      model_pend = 1'b0;
    end
    prev_row = r;
    prev_last = (c == rw.cycles - 1);
    @(posedge clk);
  endtask

  task automatic add_row(input mode_e md, input logic ld, input logic en, input logic rnd,
      input logic [W-1:0] val, input logic inj, input inject_pos_e pos, input int cyc,
      input err_kind_e kind);
    row_t rw;
    rw.mode = md;
    rw.load = ld;
    rw.enable = en;
    rw.use_lfsr = rnd;
    rw.value = val;
    rw.inject = inj;
    rw.pos = pos;
    rw.cycles = cyc;
    rw.kind = kind;
    rows.push_back(rw);
  endtask

  task automatic build_table();
    add_row(mode_siso_right, 1'b0, 1'b1, 1'b1, '0, 1'b0, inj_d0, W + 4, err_none);
    add_row(mode_siso_left, 1'b0, 1'b1, 1'b1, '0, 1'b0, inj_d0, W + 4, err_none);
    add_row(mode_siso_right, 1'b0, 1'b1, 1'b0, 64'h0000_0000_0000_00b5, 1'b0, inj_d0, 8,
            err_none);
    // piso load, then drain with zero fill.
    add_row(mode_piso, 1'b1, 1'b1, 1'b1, '0, 1'b0, inj_d0, 1, err_none);
    add_row(mode_piso, 1'b0, 1'b1, 1'b0, '0, 1'b0, inj_d0, W + 2, err_none);
    add_row(mode_pipo, 1'b1, 1'b1, 1'b0, 64'h0123_4567_89ab_cdef, 1'b0, inj_d0, 1, err_none);
    add_row(mode_pipo, 1'b0, 1'b1, 1'b0, '0, 1'b0, inj_d0, 5, err_none);
    for (int p = 0; p < 7; p++) begin
      add_row(mode_pipo, 1'b1, 1'b1, 1'b1, '0, 1'b0, inj_d0, 1, err_none);
      add_row(mode_pipo, 1'b0, 1'b0, 1'b0, '0, 1'b1, inject_pos_e'(p), 1,
              (p < 4) ? err_data : err_check);
      add_row(mode_pipo, 1'b0, 1'b0, 1'b0, '0, 1'b0, inj_d0, 1, err_none);
    end
    // inject, then shift at once from the corrected word.
    add_row(mode_pipo, 1'b1, 1'b1, 1'b1, '0, 1'b0, inj_d0, 1, err_none);
    add_row(mode_pipo, 1'b0, 1'b0, 1'b0, '0, 1'b1, inj_d0, 1, err_data);
    add_row(mode_siso_right, 1'b0, 1'b1, 1'b1, '0, 1'b0, inj_d0, 3, err_none);
    add_row(mode_pipo, 1'b1, 1'b1, 1'b1, '0, 1'b0, inj_d0, 1, err_none);
    add_row(mode_pipo, 1'b0, 1'b0, 1'b0, '0, 1'b1, inj_d1, 1, err_data);
    add_row(mode_siso_left, 1'b0, 1'b1, 1'b1, '0, 1'b0, inj_d0, 3, err_none);
    add_row(mode_pipo, 1'b0, 1'b0, 1'b0, '0, 1'b0, inj_d0, 6, err_none);
  endtask

  initial begin
    rst <= 1'b0;
    enable <= 1'b0;
    mode <= mode_siso_right;
    load <= 1'b0;
    serial_in <= 1'b0;
    parallel_in <= '0;
    inject <= 1'b0;
    inject_pos <= inj_d0;
    lfsr_state = 32'h29f;
    model_word = '0;
    model_pend = 1'b0;
    model_pos = inj_d0;
    errors = 0;
    prev_row = 0;
    prev_last = 1'b0;
    build_table();
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    check_word('0, parallel_out);
    check_bit(1'b0, serial_out);
    check_kind(err_none, err_kind);
    $display("test reset %s", (errors == 0) ? "passed" : "failed");
    row_base = errors;
    @(posedge clk);
    for (int r = 0; r < rows.size(); r++) begin
      for (int c = 0; c < rows[r].cycles; c++) begin
        step(r, c);
      end
    end
    @(negedge clk);
    check_outputs();
    close_row();
    $display("%0d tests run, %0d checks failed", rows.size() + 1, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    int total;
    int limit_ns;
    total = 0;
    #1;
    foreach (rows[i]) begin
      total += rows[i].cycles;
    end
    limit_ns = (total + reset_cycles + 4) * period_ns + 100;
    #(limit_ns);
    $display("timeout: the run did not finish within %0d ns", limit_ns);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
hw/shift_pkg.sv
hw/ecc_pkg.sv
hw/syndrome_calc.sv
hw/error_corrector.sv
hw/shift_datapath.sv
hw/ecc_shift_register.sv
tests/tb_ecc_shift_register.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with verilator, runs it and looks for the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
  --top-module tb_ecc_shift_register \
  -f compile.f \
  -o tb_sim \
  || { echo "verilator build failed"; exit 1; }

output="$(./obj_dir/tb_sim)" \
  || { echo "$output"; echo "simulation exited with an error"; exit 1; }

echo "$output"

echo "$output" | grep -qx "NO ERRORS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
